//--- logic/issue_config.svh
`ifndef ISSUE_CONFIG_SVH
`define ISSUE_CONFIG_SVH

// Data word and PC width
`define ISSUE_XLEN 32

// Architectural registers x0..x31
`define ISSUE_NUM_REGS 32

// ROB tag width, tag 0 reserved for no dependency
`define ISSUE_TAG_W 3

`endif

//--- logic/issue_pkg.sv
`default_nettype none

`include "issue_config.svh"

package issue_pkg;

    typedef logic [`ISSUE_XLEN-1:0]             word_t;
    typedef logic [$clog2(`ISSUE_NUM_REGS)-1:0] reg_idx_t;
    typedef logic [`ISSUE_TAG_W-1:0]            tag_t;
    typedef logic [3:0]                         alu_op_t;  // {inst[30], funct3}
    typedef logic [2:0]                         mem_op_t;  // Load/store funct3

    typedef enum logic {
        ST_ISSUE,
        ST_REDIRECT
    } issue_state_e;

    typedef struct packed {
        word_t inst;
        word_t pc;
    } fetch_t;

    typedef struct packed {
        logic     is_alu;      // R-type and I-type ALU
        logic     is_load;
        logic     is_store;
        logic     is_lui;
        logic     is_auipc;
        logic     is_jal;
        logic     is_illegal;
        reg_idx_t rd;          // Zero for classes without a destination
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic     uses_rs2;
        alu_op_t  alu_op;
        mem_op_t  mem_op;
        word_t    imm;         // Sign extended, or shift amount
        logic     writes_rd;
    } decoded_t;

    // Tag 0 means the value is valid
    typedef struct packed {
        word_t value;
        tag_t  tag;
    } operand_t;

    typedef struct packed {
        tag_t  tag;            // 0 when idle
        word_t value;
    } cdb_t;

    typedef struct packed {
        tag_t     tag;
        reg_idx_t rd;
        word_t    value;
    } commit_t;

    typedef struct packed {
        reg_idx_t rd;
        logic     value_ready;
        word_t    value;
    } rob_entry_t;

    typedef struct packed {
        alu_op_t op;
        word_t   vj;
        word_t   vk;
        tag_t    qj;
        tag_t    qk;
        tag_t    dest;
    } alu_issue_t;

    typedef struct packed {
        mem_op_t     op;
        word_t       vj;       // Base address
        tag_t        qj;
        tag_t        dest;
        logic [11:0] offset;
    } load_issue_t;

    typedef struct packed {
        mem_op_t     op;
        word_t       vj;       // Base address
        word_t       vk;       // Store data
        tag_t        qj;
        tag_t        qk;
        tag_t        dest;
        logic [11:0] offset;
    } store_issue_t;

endpackage

`default_nettype wire

//--- logic/inst_decode.sv
`timescale 1ns/100ps
`default_nettype none

module inst_decode (
    input  wire issue_pkg::word_t inst,
    output issue_pkg::decoded_t   dec
);

    localparam logic [6:0] OP_R     = 7'b0110011;
    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_AUIPC = 7'b0010111;
    localparam logic [6:0] OP_JAL   = 7'b1101111;
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic                is_shift;
    issue_pkg::reg_idx_t rd_field;
    issue_pkg::word_t    imm_i;
    issue_pkg::word_t    imm_s;
    issue_pkg::word_t    imm_u;
    issue_pkg::word_t    imm_j;

    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign rd_field = inst[11:7];
    assign is_shift = (funct3 == 3'b001) || (funct3 == 3'b101);  // SLLI, SRLI, SRAI

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        dec        = '0;
        dec.rs1    = inst[19:15];
        dec.rs2    = inst[24:20];
        dec.mem_op = funct3;
        dec.alu_op = {inst[30], funct3};
        case (opcode)
            OP_R: begin
                dec.is_alu   = 1'b1;
                dec.uses_rs2 = 1'b1;
                dec.rd       = rd_field;
            end
            OP_IMM: begin
                dec.is_alu = 1'b1;
                dec.rd     = rd_field;
                if (is_shift) begin
                    dec.imm = {27'b0, inst[24:20]};  // Bit 30 picks SRAI
                end else begin
                    dec.imm       = imm_i;
                    dec.alu_op[3] = 1'b0;            // Bit 30 is immediate here
                end
            end
            OP_LUI: begin
                dec.is_lui = 1'b1;
                dec.rd     = rd_field;
                dec.imm    = imm_u;
            end
            OP_AUIPC: begin
                dec.is_auipc = 1'b1;
                dec.rd       = rd_field;
                dec.imm      = imm_u;
            end
            OP_JAL: begin
                dec.is_jal = 1'b1;
                dec.rd     = rd_field;
                dec.imm    = imm_j;
            end
            OP_LOAD: begin
                dec.is_load = 1'b1;
                dec.rd      = rd_field;
                dec.imm     = imm_i;
            end
            OP_STORE: begin
                dec.is_store = 1'b1;
                dec.uses_rs2 = 1'b1;
                dec.imm      = imm_s;    // rd field holds imm bits
            end
            default: begin
                dec.is_illegal = 1'b1;
            end
        endcase
        dec.writes_rd = (dec.rd != '0);
    end

endmodule

`default_nettype wire

//--- logic/operand_select.sv
`timescale 1ns/100ps
`default_nettype none

module operand_select (
    input  wire issue_pkg::operand_t status,   // Register value and rename tag
    input  wire issue_pkg::cdb_t     cdb,
    input  wire issue_pkg::operand_t stored,   // Result table lookup of status.tag
    output issue_pkg::operand_t      operand
);

    always_comb begin
        if (status.tag == '0) begin
            operand = status;                  // Architectural value, covers x0
        end else if (cdb.tag == status.tag) begin
            operand.value = cdb.value;         // Broadcast this cycle
            operand.tag   = '0;
        end else if (stored.tag == '0) begin
            operand = stored;
        end else begin
            // Still in flight
            operand.value = '0;
            operand.tag   = status.tag;
        end
    end

endmodule

`default_nettype wire

//--- logic/register_status.sv
`timescale 1ns/100ps
`default_nettype none

`include "issue_config.svh"

module register_status (
    input  wire                       clk_in,
    input  wire                       rst_n,
    input  wire issue_pkg::reg_idx_t  rs1,
    input  wire issue_pkg::reg_idx_t  rs2,
    input  wire                       rename_valid,
    input  wire issue_pkg::reg_idx_t  rename_rd,
    input  wire issue_pkg::tag_t      rename_tag,
    input  wire                       commit_valid,
    input  wire issue_pkg::commit_t   commit,
    output issue_pkg::operand_t       src1,
    output issue_pkg::operand_t       src2
);

    issue_pkg::word_t regs [`ISSUE_NUM_REGS];
    issue_pkg::tag_t  tags [`ISSUE_NUM_REGS];   // ROB tag of the newest writer

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            for (int i = 0; i < `ISSUE_NUM_REGS; i++) begin
                regs[i] <= '0;
                tags[i] <= '0;
            end
        end else begin
            if (commit_valid && (commit.rd != '0)) begin
                regs[commit.rd] <= commit.value;
                // Only clear if no younger writer took the register
                if (tags[commit.rd] == commit.tag) begin
                    tags[commit.rd] <= '0;
                end
            end
            // Later assignment, so a same-edge rename beats the clear
            if (rename_valid && (rename_rd != '0)) begin
                tags[rename_rd] <= rename_tag;
            end
        end
    end

    assign src1.value = regs[rs1];
    assign src1.tag   = tags[rs1];
    assign src2.value = regs[rs2];
    assign src2.tag   = tags[rs2];

endmodule

`default_nettype wire

//--- logic/result_table.sv
`timescale 1ns/100ps
`default_nettype none

`include "issue_config.svh"

module result_table (
    input  wire                    clk_in,
    input  wire                    rst_n,
    input  wire issue_pkg::cdb_t   cdb,
    input  wire                    alloc_valid,
    input  wire issue_pkg::tag_t   alloc_tag,
    input  wire                    alloc_ready,   // Value known at issue
    input  wire issue_pkg::word_t  alloc_value,
    input  wire issue_pkg::tag_t   rd_tag1,
    input  wire issue_pkg::tag_t   rd_tag2,
    output issue_pkg::operand_t    res1,
    output issue_pkg::operand_t    res2
);

    localparam int NUM_TAGS = 1 << `ISSUE_TAG_W;

    issue_pkg::word_t    values [NUM_TAGS];
    logic [NUM_TAGS-1:0] ready;

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            ready <= '0;
        end else begin
            if (cdb.tag != '0) begin
                ready[cdb.tag] <= 1'b1;
            end
            if (alloc_valid) begin
                ready[alloc_tag] <= alloc_ready;  // Reused tag starts pending
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (cdb.tag != '0) begin
            values[cdb.tag] <= cdb.value;
        end
        if (alloc_valid && alloc_ready) begin
            values[alloc_tag] <= alloc_value;
        end
    end

    assign res1.value = ready[rd_tag1] ? values[rd_tag1] : '0;
    assign res1.tag   = ready[rd_tag1] ? '0 : rd_tag1;
    assign res2.value = ready[rd_tag2] ? values[rd_tag2] : '0;
    assign res2.tag   = ready[rd_tag2] ? '0 : rd_tag2;

endmodule

`default_nettype wire

//--- logic/issue_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module issue_ctrl (
    input  wire                          clk_in,
    input  wire                          rst_n,
    input  wire                          fetch_valid,
    input  wire issue_pkg::fetch_t       fetch,
    output logic                         fetch_ready,
    input  wire issue_pkg::decoded_t     dec,
    input  wire issue_pkg::operand_t     op1,
    input  wire issue_pkg::operand_t     op2,
    input  wire                          rob_full,
    input  wire issue_pkg::tag_t         rob_tag,
    input  wire                          alu_full,
    input  wire                          load_full,
    input  wire                          store_full,
    output logic                         rename_valid,
    output logic                         alloc_ready,
    output issue_pkg::word_t             alloc_value,
    output logic                         rob_alloc_valid,
    output issue_pkg::rob_entry_t        rob_entry,
    output logic                         alu_issue_valid,
    output issue_pkg::alu_issue_t        alu_issue,
    output logic                         load_issue_valid,
    output issue_pkg::load_issue_t       load_issue,
    output logic                         store_issue_valid,
    output issue_pkg::store_issue_t      store_issue,
    output logic                         redirect_valid,
    output issue_pkg::word_t             redirect_pc
);

    localparam issue_pkg::alu_op_t ALU_ADD = 4'b0000;

    issue_pkg::issue_state_e state;
    logic                    to_alu;
    logic                    station_full;
    logic                    accept;
    issue_pkg::word_t        pc_plus4;

    assign to_alu       = dec.is_alu || dec.is_auipc;
    assign station_full = (to_alu && alu_full) || (dec.is_load && load_full)
                          || (dec.is_store && store_full);
    assign fetch_ready  = (state == issue_pkg::ST_ISSUE) && !rob_full && !station_full;
    assign accept       = fetch_valid && fetch_ready;

    // Every legal class takes a ROB entry
    assign rename_valid = accept && !dec.is_illegal;
    assign pc_plus4     = fetch.pc + issue_pkg::word_t'(4);
    assign alloc_ready  = dec.is_lui || dec.is_jal;
    assign alloc_value  = dec.is_jal ? pc_plus4 : dec.imm;

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            state             <= issue_pkg::ST_ISSUE;
            rob_alloc_valid   <= 1'b0;
            alu_issue_valid   <= 1'b0;
            load_issue_valid  <= 1'b0;
            store_issue_valid <= 1'b0;
            redirect_valid    <= 1'b0;
        end else begin
            case (state)
                issue_pkg::ST_ISSUE: begin
                    if (accept && dec.is_jal) begin
                        state <= issue_pkg::ST_REDIRECT;
                    end
                end
                issue_pkg::ST_REDIRECT: begin
                    state <= issue_pkg::ST_ISSUE;   // Fetcher restarts at target
                end
                default: begin
                    state <= issue_pkg::ST_ISSUE;
                end
            endcase
            rob_alloc_valid   <= rename_valid;
            alu_issue_valid   <= accept && to_alu;
            load_issue_valid  <= accept && dec.is_load;
            store_issue_valid <= accept && dec.is_store;
            redirect_valid    <= accept && dec.is_jal;
        end
    end

    // Payloads, qualified by the valids above
    always_ff @(posedge clk_in) begin
        if (accept) begin
            rob_entry.rd          <= dec.writes_rd ? dec.rd : '0;
            rob_entry.value_ready <= alloc_ready;
            rob_entry.value       <= alloc_ready ? alloc_value : '0;

            // AUIPC becomes PC + U immediate
            alu_issue.op   <= dec.is_auipc ? ALU_ADD : dec.alu_op;
            alu_issue.vj   <= dec.is_auipc ? fetch.pc : op1.value;
            alu_issue.qj   <= dec.is_auipc ? '0 : op1.tag;
            alu_issue.vk   <= dec.uses_rs2 ? op2.value : dec.imm;
            alu_issue.qk   <= dec.uses_rs2 ? op2.tag : '0;
            alu_issue.dest <= rob_tag;

            load_issue.op     <= dec.mem_op;
            load_issue.vj     <= op1.value;
            load_issue.qj     <= op1.tag;
            load_issue.dest   <= rob_tag;
            load_issue.offset <= dec.imm[11:0];

            store_issue.op     <= dec.mem_op;
            store_issue.vj     <= op1.value;
            store_issue.vk     <= op2.value;
            store_issue.qj     <= op1.tag;
            store_issue.qk     <= op2.tag;
            store_issue.dest   <= rob_tag;
            store_issue.offset <= dec.imm[11:0];

            redirect_pc <= fetch.pc + dec.imm;  // JAL target
        end
    end

endmodule

`default_nettype wire

//--- logic/issue_unit.sv
`timescale 1ns/100ps
`default_nettype none

module issue_unit (
    input  wire                          clk_in,
    input  wire                          rst_n,
    input  wire                          fetch_valid,
    input  wire issue_pkg::fetch_t       fetch,
    output wire                          fetch_ready,
    input  wire                          rob_full,
    input  wire issue_pkg::tag_t         rob_tag,
    input  wire                          alu_full,
    input  wire                          load_full,
    input  wire                          store_full,
    input  wire issue_pkg::cdb_t         cdb,
    input  wire                          commit_valid,
    input  wire issue_pkg::commit_t      commit,
    output wire                          rob_alloc_valid,
    output wire issue_pkg::rob_entry_t   rob_entry,
    output wire                          alu_issue_valid,
    output wire issue_pkg::alu_issue_t   alu_issue,
    output wire                          load_issue_valid,
    output wire issue_pkg::load_issue_t  load_issue,
    output wire                          store_issue_valid,
    output wire issue_pkg::store_issue_t store_issue,
    output wire                          redirect_valid,
    output wire issue_pkg::word_t        redirect_pc
);

    issue_pkg::decoded_t dec;
    issue_pkg::operand_t src1;
    issue_pkg::operand_t src2;
    issue_pkg::operand_t res1;
    issue_pkg::operand_t res2;
    issue_pkg::operand_t op1;
    issue_pkg::operand_t op2;
    logic                rename_valid;
    logic                alloc_ready;
    issue_pkg::word_t    alloc_value;

    inst_decode u_decode (
        .inst (fetch.inst),
        .dec  (dec)
    );

    register_status u_regs (
        .clk_in       (clk_in),
        .rst_n        (rst_n),
        .rs1          (dec.rs1),
        .rs2          (dec.rs2),
        .rename_valid (rename_valid),
        .rename_rd    (dec.rd),
        .rename_tag   (rob_tag),
        .commit_valid (commit_valid),
        .commit       (commit),
        .src1         (src1),
        .src2         (src2)
    );

    // Looked up by rename tag
    result_table u_results (
        .clk_in      (clk_in),
        .rst_n       (rst_n),
        .cdb         (cdb),
        .alloc_valid (rename_valid),
        .alloc_tag   (rob_tag),
        .alloc_ready (alloc_ready),
        .alloc_value (alloc_value),
        .rd_tag1     (src1.tag),
        .rd_tag2     (src2.tag),
        .res1        (res1),
        .res2        (res2)
    );

    operand_select u_sel1 (
        .status  (src1),
        .cdb     (cdb),
        .stored  (res1),
        .operand (op1)
    );

    operand_select u_sel2 (
        .status  (src2),
        .cdb     (cdb),
        .stored  (res2),
        .operand (op2)
    );

    issue_ctrl u_ctrl (
        .clk_in            (clk_in),
        .rst_n             (rst_n),
        .fetch_valid       (fetch_valid),
        .fetch             (fetch),
        .fetch_ready       (fetch_ready),
        .dec               (dec),
        .op1               (op1),
        .op2               (op2),
        .rob_full          (rob_full),
        .rob_tag           (rob_tag),
        .alu_full          (alu_full),
        .load_full         (load_full),
        .store_full        (store_full),
        .rename_valid      (rename_valid),
        .alloc_ready       (alloc_ready),
        .alloc_value       (alloc_value),
        .rob_alloc_valid   (rob_alloc_valid),
        .rob_entry         (rob_entry),
        .alu_issue_valid   (alu_issue_valid),
        .alu_issue         (alu_issue),
        .load_issue_valid  (load_issue_valid),
        .load_issue        (load_issue),
        .store_issue_valid (store_issue_valid),
        .store_issue       (store_issue),
        .redirect_valid    (redirect_valid),
        .redirect_pc       (redirect_pc)
    );

endmodule

`default_nettype wire

//--- tests/issue_unit_props.sv
`timescale 1ns/100ps
`default_nettype none

module issue_unit_props (
    input wire clk_in,
    input wire rst_n,
    input wire fetch_ready,
    input wire alu_full,
    input wire load_full,
    input wire store_full,
    input wire rob_alloc_valid,
    input wire alu_issue_valid,
    input wire load_issue_valid,
    input wire store_issue_valid,
    input wire redirect_valid
);

    a_one_station: assert property (@(posedge clk_in) disable iff (!rst_n)
        $onehot0({alu_issue_valid, load_issue_valid, store_issue_valid}))
        else $error("more than one station valid");

    a_redirect_rob: assert property (@(posedge clk_in) disable iff (!rst_n)
        redirect_valid |-> rob_alloc_valid) else $error("redirect without ROB entry");

    // Station full flag seen on the accepting edge
    a_alu_room: assert property (@(posedge clk_in) disable iff (!rst_n)
        alu_issue_valid |-> !$past(alu_full)) else $error("ALU issue while full");
    a_load_room: assert property (@(posedge clk_in) disable iff (!rst_n)
        load_issue_valid |-> !$past(load_full)) else $error("load issue while full");
    a_store_room: assert property (@(posedge clk_in) disable iff (!rst_n)
        store_issue_valid |-> !$past(store_full)) else $error("store issue while full");

    a_redirect_stall: assert property (@(posedge clk_in) disable iff (!rst_n)
        redirect_valid |-> !fetch_ready) else $error("fetch_ready high in redirect cycle");

endmodule

bind issue_unit issue_unit_props u_props (.*);

`default_nettype wire

//--- tests/issue_unit_tb.sv
`timescale 1ns/100ps
`default_nettype none

module issue_unit_tb;

    localparam time PERIOD       = 100;
    localparam int  RESET_CYCLES = 5;
    localparam int  MIXED_CYCLES = 500;
    localparam int  BP_CYCLES    = 350;
    localparam int  DEP_CYCLES   = 350;
    localparam int  TEST_CYCLES  = MIXED_CYCLES + BP_CYCLES + DEP_CYCLES;

    logic clk_in, rst_n, fetch_valid, fetch_ready, rob_full, alu_full, load_full, store_full;
    logic commit_valid, rob_alloc_valid, alu_issue_valid, load_issue_valid;
    logic store_issue_valid, redirect_valid;
    issue_pkg::fetch_t       fetch;
    issue_pkg::tag_t         rob_tag;
    issue_pkg::cdb_t         cdb;
    issue_pkg::commit_t      commit;
    issue_pkg::rob_entry_t   rob_entry, exp_rob;
    issue_pkg::alu_issue_t   alu_issue, exp_alu;
    issue_pkg::load_issue_t  load_issue, exp_load;
    issue_pkg::store_issue_t store_issue, exp_store;
    issue_pkg::word_t        redirect_pc, exp_target;

    logic [15:0] lfsr;
    int n_checks, n_errors;
    logic exp_rob_v, exp_alu_v, exp_load_v, exp_store_v, exp_redir_v, in_redirect;

    // Reference model state
    issue_pkg::word_t    m_regs [32];
    issue_pkg::tag_t     m_tags [32];
    logic                m_ready [8];
    issue_pkg::word_t    m_vals [8];
    issue_pkg::reg_idx_t m_rd [8];      // Destination of each ROB tag
    issue_pkg::tag_t     rob_q [$];
    issue_pkg::tag_t     next_tag;
    issue_pkg::word_t    pc;

    // Instruction held on the fetch port
    logic                have_inst;
    int                  cur_cls;      // 0 R, 1 I, 2 LUI, 3 AUIPC, 4 JAL, 5 load, 6 store, 7 bad
    issue_pkg::reg_idx_t cur_rd, cur_rs1, cur_rs2;
    issue_pkg::alu_op_t  cur_op;
    issue_pkg::word_t    cur_imm;

    issue_unit u_dut (.*);

    initial begin
        clk_in = 1'b0;
        forever #(PERIOD / 2) clk_in = ~clk_in;
    end

    initial begin
        #((RESET_CYCLES + TEST_CYCLES + 50) * PERIOD);
        $display("Timeout, the run did not reach its end");
        $display("*** FAILED ***");
        $finish;
    end

    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[30:0], lfsr_step()};
        return v;
    endfunction

    task automatic check_bit(string name, logic got, logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERROR t=%0t %s exp=%b got=%b", $time, name, exp, got);
        end
    endtask

    task automatic check_word(string name, issue_pkg::word_t got, issue_pkg::word_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERROR t=%0t %s exp=%h got=%h", $time, name, exp, got);
        end
    endtask

    task automatic check_rob(issue_pkg::rob_entry_t got, issue_pkg::rob_entry_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERROR t=%0t rob_entry exp=%h got=%h", $time, exp, got);
        end
    endtask

    task automatic check_alu(issue_pkg::alu_issue_t got, issue_pkg::alu_issue_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERROR t=%0t alu_issue exp=%h got=%h", $time, exp, got);
        end
    endtask

    task automatic check_load(issue_pkg::load_issue_t got, issue_pkg::load_issue_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERROR t=%0t load_issue exp=%h got=%h", $time, exp, got);
        end
    endtask

    task automatic check_store(issue_pkg::store_issue_t got, issue_pkg::store_issue_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERROR t=%0t store_issue exp=%h got=%h", $time, exp, got);
        end
    endtask

    task automatic check_outputs();
        check_bit("rob_alloc_valid", rob_alloc_valid, exp_rob_v);
        check_bit("alu_issue_valid", alu_issue_valid, exp_alu_v);
        check_bit("load_issue_valid", load_issue_valid, exp_load_v);
        check_bit("store_issue_valid", store_issue_valid, exp_store_v);
        check_bit("redirect_valid", redirect_valid, exp_redir_v);
        if (exp_rob_v) check_rob(rob_entry, exp_rob);
        if (exp_alu_v) check_alu(alu_issue, exp_alu);
        if (exp_load_v) check_load(load_issue, exp_load);
        if (exp_store_v) check_store(store_issue, exp_store);
        if (exp_redir_v) check_word("redirect_pc", redirect_pc, exp_target);
    endtask

    // Register, then CDB, then finished results
    function automatic issue_pkg::operand_t lookup(issue_pkg::reg_idx_t r);
        issue_pkg::operand_t o;
        issue_pkg::tag_t     t;
        t = m_tags[r];
        o = '0;
        if (r == 0 || t == 0) o.value = m_regs[r];
        else if (cdb.tag == t) o.value = cdb.value;
        else if (m_ready[t]) o.value = m_vals[t];
        else o.tag = t;
        return o;
    endfunction

    task automatic gen_inst();
        logic [2:0]  f3;
        logic        alt;
        logic [20:0] off;
        logic [11:0] imm12;
        f3      = rand_bits(3);
        alt     = rand_bits(1);
        cur_rd  = rand_bits(3);    // x0..x7 only, so dependencies are frequent
        cur_rs1 = rand_bits(3);
        cur_rs2 = rand_bits(3);
        cur_op  = {alt, f3};
        case (rand_bits(4))
            0, 1, 2, 3: begin
                cur_cls = 0;
                fetch.inst = {1'b0, alt, 5'b0, cur_rs2, cur_rs1, f3, cur_rd, 7'b0110011};
            end
            4, 5, 6, 7: begin
                cur_cls = 1;
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    cur_imm = rand_bits(5);            // Shift amount
                    fetch.inst = {1'b0, alt, 5'b0, cur_imm[4:0], cur_rs1, f3, cur_rd,
                                  7'b0010011};
                end else begin
                    imm12   = 12'(rand_bits(12));
                    cur_imm = {{20{imm12[11]}}, imm12};
                    cur_op  = {1'b0, f3};
                    fetch.inst = {cur_imm[11:0], cur_rs1, f3, cur_rd, 7'b0010011};
                end
            end
            8, 9: begin
                cur_cls    = 2 + (lfsr_step() ? 1 : 0);  // LUI or AUIPC
                cur_imm    = {20'(rand_bits(20)), 12'b0};
                fetch.inst = {cur_imm[31:12], cur_rd, (cur_cls == 2) ? 7'b0110111 : 7'b0010111};
            end
            10: begin
                cur_cls    = 4;
                off        = {20'(rand_bits(20)), 1'b0};
                cur_imm    = {{11{off[20]}}, off};
                fetch.inst = {off[20], off[10:1], off[11], off[19:12], cur_rd, 7'b1101111};
            end
            11, 12: begin
                cur_cls    = 5;
                imm12      = 12'(rand_bits(12));
                cur_imm    = {{20{imm12[11]}}, imm12};
                fetch.inst = {cur_imm[11:0], cur_rs1, f3, cur_rd, 7'b0000011};
            end
            13, 14: begin
                cur_cls    = 6;
                imm12      = 12'(rand_bits(12));
                cur_imm    = {{20{imm12[11]}}, imm12};
                fetch.inst = {cur_imm[11:5], cur_rs2, cur_rs1, f3, cur_imm[4:0], 7'b0100011};
            end
            default: begin
                cur_cls    = 7;
                fetch.inst = {25'(rand_bits(25)), 7'b1100011};   // Branch opcode, unsupported
            end
        endcase
        fetch.pc = pc;
    endtask

    // Builds expected packets for the accepted instruction
    task automatic predict();
        issue_pkg::operand_t o1, o2;
        o1 = lookup(cur_rs1);
        o2 = lookup(cur_rs2);
        exp_rob_v   = (cur_cls != 7);
        exp_rob     = '0;
        exp_rob.rd  = (cur_cls == 6) ? '0 : cur_rd;
        if (cur_cls == 2 || cur_cls == 4) begin
            exp_rob.value_ready = 1'b1;
            exp_rob.value       = (cur_cls == 2) ? cur_imm : pc + 4;
        end
        exp_alu_v   = (cur_cls <= 1) || (cur_cls == 3);
        exp_alu     = '{op: cur_op, vj: o1.value, vk: o2.value, qj: o1.tag, qk: o2.tag,
                        dest: next_tag};
        if (cur_cls != 0) begin
            exp_alu.vk = cur_imm;
            exp_alu.qk = '0;
        end
        if (cur_cls == 3) exp_alu = '{op: '0, vj: pc, vk: cur_imm, qj: '0, qk: '0, dest: next_tag};
        exp_load_v  = (cur_cls == 5);
        exp_load    = '{op: cur_op[2:0], vj: o1.value, qj: o1.tag, dest: next_tag,
                        offset: cur_imm[11:0]};
        exp_store_v = (cur_cls == 6);
        exp_store   = '{op: cur_op[2:0], vj: o1.value, vk: o2.value, qj: o1.tag, qk: o2.tag,
                        dest: next_tag, offset: cur_imm[11:0]};
        exp_redir_v = (cur_cls == 4);
        exp_target  = pc + cur_imm;
    endtask

    task automatic run_test(string name, int cycles, int full_thr, int cdb_thr);
        int          errs_before;
        int          accepted;
        logic        exp_ready;
        logic        need_full;
        issue_pkg::tag_t cands [$];
        errs_before = n_errors;
        accepted    = 0;
        repeat (cycles) begin
            @(posedge clk_in);
            #1;
            check_outputs();
            alu_full   = rand_bits(3) < full_thr;
            load_full  = rand_bits(3) < full_thr;
            store_full = rand_bits(3) < full_thr;
            cands.delete();
            foreach (rob_q[i]) if (!m_ready[rob_q[i]]) cands.push_back(rob_q[i]);
            cdb = '0;
            if (cands.size() > 0 && rand_bits(3) < cdb_thr) begin
                cdb.tag   = cands[rand_bits(3) % cands.size()];
                cdb.value = rand_bits(32);
            end
            commit_valid = 1'b0;
            if (rob_q.size() > 0 && m_ready[rob_q[0]] && lfsr_step()) begin
                commit_valid = 1'b1;
                commit.tag   = rob_q[0];
                commit.rd    = m_rd[rob_q[0]];
                commit.value = m_vals[rob_q[0]];
            end
            if (!have_inst && rand_bits(3) != 0) begin
                gen_inst();
                have_inst = 1'b1;
            end
            fetch_valid = have_inst;
            rob_full    = (rob_q.size() == 7);
            rob_tag     = next_tag;
            #1;
            need_full = ((cur_cls <= 1 || cur_cls == 3) && alu_full)
                        || (cur_cls == 5 && load_full) || (cur_cls == 6 && store_full);
            exp_ready = !in_redirect && !rob_full && !(have_inst && need_full);
            if (have_inst) check_bit("fetch_ready", fetch_ready, exp_ready);
            {exp_rob_v, exp_alu_v, exp_load_v, exp_store_v, exp_redir_v} = '0;
            in_redirect = 1'b0;
            if (have_inst && exp_ready) predict();
            // Model update for the coming edge, rename last so it wins
            if (commit_valid) begin
                void'(rob_q.pop_front());
                if (commit.rd != 0) m_regs[commit.rd] = commit.value;
                if (m_tags[commit.rd] == commit.tag) m_tags[commit.rd] = '0;
            end
            if (cdb.tag != 0) begin
                m_ready[cdb.tag] = 1'b1;
                m_vals[cdb.tag]  = cdb.value;
            end
            if (have_inst && exp_ready) begin
                accepted++;
                have_inst = 1'b0;
                if (cur_cls != 7) begin
                    if (cur_cls != 6 && cur_rd != 0) m_tags[cur_rd] = next_tag;
                    m_ready[next_tag] = exp_rob.value_ready;
                    m_vals[next_tag]  = exp_rob.value;
                    m_rd[next_tag]    = exp_rob.rd;
                    rob_q.push_back(next_tag);
                    next_tag = (next_tag == 7) ? 1 : next_tag + 1;
                end
                in_redirect = (cur_cls == 4);
                pc          = in_redirect ? exp_target : pc + 4;
            end
        end
        $display("test %s: %0d instructions accepted, %0d errors", name, accepted,
                 n_errors - errs_before);
    endtask

    initial begin
        lfsr = 16'd49;
        rst_n = 1'b0;
        {fetch_valid, rob_full, alu_full, load_full, store_full, commit_valid} = '0;
        fetch = '0;
        rob_tag = 1;
        cdb = '0;
        commit = '0;
        {n_checks, n_errors} = '0;
        {exp_rob_v, exp_alu_v, exp_load_v, exp_store_v, exp_redir_v, in_redirect} = '0;
        {have_inst, cur_cls} = '0;
        foreach (m_regs[i]) {m_regs[i], m_tags[i]} = '0;
        foreach (m_ready[i]) m_ready[i] = 1'b0;
        next_tag = 1;
        pc = 32'h0000_1000;
        repeat (RESET_CYCLES) begin
            @(posedge clk_in);
            #1;
            check_outputs();
        end
        rst_n = 1'b1;
        @(posedge clk_in);
        #1;
        check_outputs();
        $display("test reset: %0d errors", n_errors);
        run_test("mixed issue", MIXED_CYCLES, 1, 4);
        run_test("back-pressure", BP_CYCLES, 5, 3);
        run_test("dependency resolution", DEP_CYCLES, 1, 1);
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+logic
logic/issue_pkg.sv
logic/inst_decode.sv
logic/operand_select.sv
logic/register_status.sv
logic/result_table.sv
logic/issue_ctrl.sv
logic/issue_unit.sv
tests/issue_unit_props.sv
tests/issue_unit_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wall -f flist.f --top-module issue_unit_tb
out=$(./obj_dir/Vissue_unit_tb)
echo "$out"
if echo "$out" | grep -q '\*\*\* PASSED \*\*\*'; then
    exit 0
fi
exit 1
